/* tb.f */
source/sifhPkg.sv
source/binAddressStage.sv
source/binAccumulator.sv
source/peakTracker.sv
source/windowCalc.sv
source/axiLiteRegs.sv
source/sifhTop.sv
dv/clkGen.sv
dv/sifhTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= sifhTb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "RESULT: PASS"

clean:
	rm -rf $(OBJ_DIR)

/* dv/sifhTb.sv */
`timescale 1ns/1ps

module sifhTb import sifhPkg::*; ();

    localparam int PASS_LEN    = DATA_NUM * PIXELS * ACQ_NUM;
    localparam int CYCLE_LIMIT = 2 * (2 * 2 * PASS_LEN) + 200;  // two runs of two passes

    logic              clk, combin_res, sampleValid, sampleReady;
    logic [NP-1:0]     sample;
    logic              awvalid, awready, wvalid, wready, bvalid, bready;
    logic              arvalid, arready, rvalid, rready;
    logic [AXI_AW-1:0] awaddr, araddr, readAddr;
    logic [AXI_DW-1:0] wdata, rdata, expRead, lastRead;
    logic [1:0]        bresp, rresp;
    logic              lastCoarse, readyOff, expReadOn;
    logic [15:0]       lfsr = 16'd98;
    logic [NP-1:0]     stim [2*PASS_LEN];  // coarse pass, then fine pass
    int                expResult [PIXELS];
    int                acceptCnt, turnCnt;
    int                mismatchCount = 0;
    int                failCount = 0;

    clkGen u_clk (.clk);

    sifhTop u_dut (.*);

    function automatic logic [15:0] lfsrNext(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);  // Galois taps 16,14,13,11
    endfunction

    function automatic int unsigned randBits(input int n);
        int unsigned v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsrNext(lfsr);
            v = (v << 1) | 32'(lfsr[0]);
        end
        return v;
    endfunction

    task automatic noteMismatch(input string msg);
        mismatchCount++;
        $display("Mismatch at %0t: %s", $time, msg);
    endtask

    task automatic noteFailure(input string msg);
        failCount++;
        $display("Protocol error at %0t: %s", $time, msg);
    endtask

    // draws a run's timestamps and works out both histograms
    task automatic buildRun(input stampArrT centre);
        int cnt [PIXELS][BINS];
        int topCnt [PIXELS];
        int topBin [PIXELS];
        int edgeLo [PIXELS];
        int pix;
        int v;
        for (int i = 0; i < 2 * PASS_LEN; i++) begin
            pix = (i / DATA_NUM) % PIXELS;
            v = int'(centre[pix]) + int'(randBits(4)) - 8;  // jitter -8..7
            stim[i] = NP'((v < 0) ? 0 : (v > 255) ? 255 : v);
        end
        for (int pn = 0; pn < 2; pn++) begin
            for (int p = 0; p < PIXELS; p++) begin
                topCnt[p] = 0;
                topBin[p] = 0;
                for (int b = 0; b < BINS; b++) cnt[p][b] = 0;
            end
            for (int i = 0; i < PASS_LEN; i++) begin
                pix = (i / DATA_NUM) % PIXELS;
                if (pn == 0) v = int'(stim[i]) / COARSE_W;
                else v = int'(stim[PASS_LEN + i]) - edgeLo[pix];
                if (v >= 0 && v < BINS) begin  // outside the window is dropped
                    cnt[pix][v]++;
                    if (cnt[pix][v] > topCnt[pix]) begin  // first bin to the top keeps it
                        topCnt[pix] = cnt[pix][v];
                        topBin[pix] = v;
                    end
                end
            end
            for (int p = 0; p < PIXELS; p++) begin
                v = topBin[p] * COARSE_W - SB;
                if (pn == 0) edgeLo[p] = (v < 0) ? 0 : (v > WIN_MAX) ? WIN_MAX : v;
                else expResult[p] = edgeLo[p] + topBin[p];
            end
        end
    endtask

    task automatic axiWrite(input logic [AXI_AW-1:0] addr, input logic [AXI_DW-1:0] data);
        logic awGo;
        logic wGo;
        awvalid = 1'b1;
        awaddr  = addr;
        wvalid  = 1'b1;
        wdata   = data;
        while (awvalid || wvalid) begin
            awGo = awvalid && awready;  // readies only move on rising edges
            wGo  = wvalid && wready;
            @(negedge clk);
            if (awGo) awvalid = 1'b0;
            if (wGo) wvalid = 1'b0;
        end
        repeat (randBits(2)) @(negedge clk);  // late BREADY now and then
        bready = 1'b1;
        while (!bvalid) @(negedge clk);
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic axiRead(input logic [AXI_AW-1:0] addr, input logic [AXI_DW-1:0] expected,
                           input logic check);
        arvalid   = 1'b1;
        araddr    = addr;
        readAddr  = addr;
        expRead   = expected;
        expReadOn = check;
        while (!arready) @(negedge clk);
        @(negedge clk);
        arvalid = 1'b0;
        repeat (randBits(2)) @(negedge clk);  // RDATA has to hold meanwhile
        rready = 1'b1;
        while (!rvalid) @(negedge clk);
        @(negedge clk);
        rready    = 1'b0;
        expReadOn = 1'b0;
    endtask

    task automatic sendPass(input int first);
        int startCnt = acceptCnt;
        while (acceptCnt - startCnt < PASS_LEN) begin
            sample      = stim[first + acceptCnt - startCnt];
            sampleValid = (randBits(2) != 0);  // pause about one cycle in four
            lastCoarse  = (first == 0) && (acceptCnt - startCnt == PASS_LEN - 1);
            @(negedge clk);
        end
        sampleValid = 1'b0;
        lastCoarse  = 1'b0;
    endtask

    task automatic runOnce(input stampArrT centre);
        buildRun(centre);
        readyOff = 1'b0;
        axiWrite(5'h00, 32'h1);
        axiRead(5'h04, 32'h1, 1'b1);  // busy, coarse, done cleared
        sendPass(0);
        while (!sampleReady) @(negedge clk);
        axiRead(5'h04, 32'h5, 1'b1);  // busy, fine
        sendPass(PASS_LEN);
        readyOff = 1'b1;
        do begin
            axiRead(5'h04, '0, 1'b0);
        end while (!lastRead[1]);
        axiRead(5'h04, 32'h2, 1'b1);
        for (int p = 0; p < PIXELS; p++) begin
            axiRead(AXI_AW'(8 + 4 * p), AXI_DW'(expResult[p]), 1'b1);
        end
    endtask

    task automatic reportAndStop();
        $display("mismatches %0d, other failures %0d", mismatchCount, failCount);
        if (mismatchCount == 0 && failCount == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    endtask

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            acceptCnt <= 0;
            turnCnt   <= 0;
            lastRead  <= '0;
        end else begin
            if (sampleValid && sampleReady) acceptCnt <= acceptCnt + 1;
            if (sampleValid && sampleReady && lastCoarse) turnCnt <= 1;  // turnaround starts
            else if (turnCnt > 0 && turnCnt < 4) turnCnt <= turnCnt + 1;
            else turnCnt <= 0;
            if (rvalid && rready) lastRead <= rdata;
        end
    end

    readValue: assert property (@(posedge clk) disable iff (!combin_res)
        rvalid && rready && expReadOn |-> rdata == expRead && rresp == 2'b00)
        else noteMismatch($sformatf("read 0x%0h resp %0d at 0x%0h, expected 0x%0h",
                                    $sampled(rdata), $sampled(rresp), readAddr, expRead));
    writeResp: assert property (@(posedge clk) disable iff (!combin_res)
        bvalid && bready |-> bresp == 2'b00)
        else noteMismatch($sformatf("write resp %0d, expected OKAY", $sampled(bresp)));
    idleReady: assert property (@(posedge clk) disable iff (!combin_res)
        readyOff |-> !sampleReady) else noteMismatch("sampleReady high while idle");
    turnLow: assert property (@(posedge clk) disable iff (!combin_res)
        turnCnt > 0 && turnCnt < 4 |-> !sampleReady)
        else noteMismatch("sampleReady high during the turnaround");
    turnHigh: assert property (@(posedge clk) disable iff (!combin_res)
        turnCnt == 4 |-> sampleReady) else noteMismatch("sampleReady not back after windowLoad");
    rHold: assert property (@(posedge clk) disable iff (!combin_res)
        rvalid && !rready |=> rvalid && $stable(rdata))
        else noteFailure("R channel changed before RREADY");
    bHold: assert property (@(posedge clk) disable iff (!combin_res)
        bvalid && !bready |=> bvalid) else noteFailure("BVALID dropped before BREADY");

    initial begin
        {combin_res, sampleValid, lastCoarse, expReadOn} = '0;
        {awvalid, wvalid, bready, arvalid, rready} = '0;
        sample   = '0;
        awaddr   = '0;
        araddr   = '0;
        readAddr = '0;
        wdata    = '0;
        expRead  = '0;
        readyOff = 1'b1;
        repeat (5) @(negedge clk);
        combin_res = 1'b1;
        axiRead(5'h04, '0, 1'b1);  // idle status
        axiRead(5'h18, '0, 1'b1);  // unmapped word
        runOnce({8'd252, 8'd170, 8'd90, 8'd3});
        runOnce({8'd130, 8'd5, 8'd40, 8'd250});
        reportAndStop();
    end

    initial begin
        int cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        failCount++;
        $display("Timeout: run still going after %0d cycles", CYCLE_LIMIT);
        reportAndStop();
    end

endmodule

/* dv/clkGen.sv */
`timescale 1ns/1ps

module clkGen (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;  // 40 ns period
    end

endmodule

/* source/sifhTop.sv */
`timescale 1ns/1ps

module sifhTop import sifhPkg::*; (
    input  logic              clk,
    input  logic              combin_res,
    input  logic              sampleValid,
    input  logic [NP-1:0]     sample,
    output logic              sampleReady,
    input  logic              awvalid,
    input  logic [AXI_AW-1:0] awaddr,
    output logic              awready,
    input  logic              wvalid,
    input  logic [AXI_DW-1:0] wdata,
    output logic              wready,
    output logic              bvalid,
    output logic [1:0]        bresp,
    input  logic              bready,
    input  logic              arvalid,
    input  logic [AXI_AW-1:0] araddr,
    output logic              arready,
    output logic              rvalid,
    output logic [AXI_DW-1:0] rdata,
    output logic [1:0]        rresp,
    input  logic              rready
);

    binReqT    binReq;
    binUpdateT binUpdate;
    peakSetT   peakSet;
    stampArrT  windowLower;
    logic      windowLoad;
    resultSetT results;
    logic      startPulse;
    runStateE  runState;
    logic      clearStage;  // histograms and maxima

    assign clearStage = windowLoad || startPulse;

    binAddressStage u_addr (.clk, .combin_res, .startPulse, .sampleValid, .sample,
                            .windowLower, .windowLoad, .sampleReady, .runState, .binReq);

    binAccumulator u_acc (.clk, .combin_res, .binReq, .clearHist(clearStage), .binUpdate);

    peakTracker u_peak (.clk, .combin_res, .binUpdate, .clearPeaks(clearStage), .peakSet);

    windowCalc u_win (.clk, .combin_res, .peakSet, .startPulse, .windowLower,
                      .windowLoad, .results);

    axiLiteRegs u_regs (.clk, .combin_res, .runState, .results, .awvalid, .awaddr,
                        .awready, .wvalid, .wdata, .wready, .bvalid, .bresp, .bready,
                        .arvalid, .araddr, .arready, .rvalid, .rdata, .rresp, .rready,
                        .startPulse);

endmodule

/* source/axiLiteRegs.sv */
`timescale 1ns/1ps

module axiLiteRegs import sifhPkg::*; (
    input  logic              clk,
    input  logic              combin_res,
    input  runStateE          runState,
    input  resultSetT         results,
    input  logic              awvalid,
    input  logic [AXI_AW-1:0] awaddr,
    output logic              awready,
    input  logic              wvalid,
    input  logic [AXI_DW-1:0] wdata,
    output logic              wready,
    output logic              bvalid,
    output logic [1:0]        bresp,
    input  logic              bready,
    input  logic              arvalid,
    input  logic [AXI_AW-1:0] araddr,
    output logic              arready,
    output logic              rvalid,
    output logic [AXI_DW-1:0] rdata,
    output logic [1:0]        rresp,
    input  logic              rready,
    output logic              startPulse
);

    logic              awHeld;     // address taken, data still missing
    logic              wHeld;
    logic [AXI_AW-1:0] awAddrReg;
    logic [AXI_DW-1:0] wDataReg;
    logic [AXI_AW-1:0] wrAddr;
    logic [AXI_DW-1:0] wrData;
    logic              doWrite;
    logic [AXI_DW-1:0] readData;
    regIdxE            rdIdx;

    assign awready = !awHeld && !bvalid;
    assign wready  = !wHeld && !bvalid;
    assign arready = !rvalid;
    assign bresp   = 2'b00;  // always OKAY
    assign rresp   = 2'b00;

    assign wrAddr  = awHeld ? awAddrReg : awaddr;
    assign wrData  = wHeld ? wDataReg : wdata;
    assign doWrite = (awHeld || (awvalid && awready)) && (wHeld || (wvalid && wready));

    always_ff @(posedge clk) begin
        if (awvalid && awready) awAddrReg <= awaddr;
        if (wvalid && wready) wDataReg <= wdata;
        if (arvalid && arready) rdata <= readData;
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            awHeld     <= 1'b0;
            wHeld      <= 1'b0;
            bvalid     <= 1'b0;
            startPulse <= 1'b0;
        end else begin
            startPulse <= doWrite && (regIdxE'(wrAddr[AXI_AW-1:2]) == REG_CTRL) && wrData[0];
            if (doWrite) begin
                awHeld <= 1'b0;
                wHeld  <= 1'b0;
                bvalid <= 1'b1;
            end else begin
                if (awvalid && awready) awHeld <= 1'b1;
                if (wvalid && wready) wHeld <= 1'b1;
                if (bvalid && bready) bvalid <= 1'b0;
            end
        end
    end

    assign rdIdx = regIdxE'(araddr[AXI_AW-1:2]);

    always_comb begin
        case (rdIdx)
            REG_STATUS: readData = AXI_DW'({runState == RUN_FINE, results.done,
                                            runState != RUN_IDLE});
            REG_RES0:   readData = AXI_DW'(results.result[0]);
            REG_RES1:   readData = AXI_DW'(results.result[1]);
            REG_RES2:   readData = AXI_DW'(results.result[2]);
            REG_RES3:   readData = AXI_DW'(results.result[3]);
            default:    readData = '0;  // control and unmapped words
        endcase
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            rvalid <= 1'b0;
        end else if (arvalid && arready) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    rdataHold: assert property (@(posedge clk) disable iff (!combin_res)
        rvalid && !rready |=> rvalid && $stable(rdata));

endmodule

/* source/windowCalc.sv */
`timescale 1ns/1ps

module windowCalc import sifhPkg::*; (
    input  logic      clk,
    input  logic      combin_res,
    input  peakSetT   peakSet,
    input  logic      startPulse,
    output stampArrT  windowLower,
    output logic      windowLoad,
    output resultSetT results
);

    stampArrT edgeReg;    // edges of the current fine pass
    stampArrT resultReg;
    logic     doneReg;
    logic     fineDone;

    assign windowLoad = peakSet.valid && (peakSet.pass == PASS_COARSE);
    assign fineDone   = peakSet.valid && (peakSet.pass == PASS_FINE);

    // lower edge is coarse peak start minus half a bin, clamped
    always_comb begin
        int lo;
        for (int p = 0; p < PIXELS; p++) begin
            lo = int'(peakSet.peakBin[p]) * COARSE_W - SB;
            if (lo < 0) begin
                lo = 0;
            end else if (lo > WIN_MAX) begin
                lo = WIN_MAX;
            end
            windowLower[p] = NP'(lo);
        end
    end

    always_ff @(posedge clk) begin
        if (windowLoad) begin
            edgeReg <= windowLower;
        end
        if (fineDone) begin
            for (int p = 0; p < PIXELS; p++) begin
                resultReg[p] <= edgeReg[p] + NP'(peakSet.peakBin[p]);
            end
        end
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            doneReg <= 1'b0;
        end else if (startPulse) begin
            doneReg <= 1'b0;
        end else if (fineDone) begin
            doneReg <= 1'b1;
        end
    end

    assign results = '{result: resultReg, done: doneReg};

endmodule

/* source/peakTracker.sv */
`timescale 1ns/1ps

module peakTracker import sifhPkg::*; (
    input  logic      clk,
    input  logic      combin_res,
    input  binUpdateT binUpdate,
    input  logic      clearPeaks,
    output peakSetT   peakSet
);

    logic [PIXELS-1:0][COUNT_W-1:0] maxCount;
    binArrT                         maxBin;
    binArrT                         nextBin;  // peak bins including this update
    logic                           newMax;

    // strictly greater, so a tie keeps the bin that got there first
    assign newMax = binUpdate.valid && (binUpdate.count > maxCount[binUpdate.pixel]);

    always_comb begin
        nextBin = maxBin;
        if (newMax) begin
            nextBin[binUpdate.pixel] = binUpdate.bin;
        end
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            maxCount <= '0;
            maxBin   <= '0;
        end else if (clearPeaks) begin
            maxCount <= '0;
            maxBin   <= '0;
        end else if (newMax) begin
            maxCount[binUpdate.pixel] <= binUpdate.count;
            maxBin                    <= nextBin;
        end
    end

    // one-cycle peak set at the end of each pass
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            peakSet <= '0;
        end else if (clearPeaks) begin
            peakSet.valid <= 1'b0;
        end else begin
            peakSet.valid   <= binUpdate.lastOfPass;  // valid of the update is not needed
            peakSet.pass    <= binUpdate.pass;
            peakSet.peakBin <= nextBin;
        end
    end

endmodule

/* source/binAccumulator.sv */
`timescale 1ns/1ps

module binAccumulator import sifhPkg::*; (
    input  logic      clk,
    input  logic      combin_res,
    input  binReqT    binReq,
    input  logic      clearHist,
    output binUpdateT binUpdate
);

    logic [COUNT_W-1:0]    countMem [HIST_DEPTH];
    logic [HIST_DEPTH-1:0] entryValid;  // clear bit means the bin reads zero
    logic [PIX_W+NB-1:0]   reqAddr;
    logic [PIX_W+NB-1:0]   wbAddr;
    logic                  forward;
    logic [COUNT_W-1:0]    readCount;

    assign reqAddr = {binReq.pixel, binReq.bin};
    assign wbAddr  = {binUpdate.pixel, binUpdate.bin};

    // memory is written one cycle after the count is formed,
    // so a repeat of the same bin takes the pending value
    assign forward = binUpdate.valid && (wbAddr == reqAddr);

    always_comb begin
        if (forward) begin
            readCount = binUpdate.count;
        end else if (entryValid[reqAddr]) begin
            readCount = countMem[reqAddr];
        end else begin
            readCount = '0;
        end
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            binUpdate <= '0;
        end else if (clearHist) begin
            binUpdate <= '0;  // nothing pending after a clear
        end else begin
            binUpdate.pixel      <= binReq.pixel;
            binUpdate.bin        <= binReq.bin;
            binUpdate.pass       <= binReq.pass;
            binUpdate.lastOfPass <= binReq.lastOfPass;
            binUpdate.valid      <= binReq.valid;
            binUpdate.count      <= readCount + 1'b1;
        end
    end

    // valid bits, cleared in one cycle
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            entryValid <= '0;
        end else if (clearHist) begin
            entryValid <= '0;
        end else if (binUpdate.valid) begin
            entryValid[wbAddr] <= 1'b1;
        end
    end

    // write back the registered count
    always_ff @(posedge clk) begin
        if (binUpdate.valid) begin
            countMem[wbAddr] <= binUpdate.count;
        end
    end

    // upstream sample counting bounds every bin to MAX_COUNT
    countBelowMax: assert property (@(posedge clk) disable iff (!combin_res)
        binReq.valid && !clearHist |-> readCount < COUNT_W'(MAX_COUNT));

endmodule

/* source/binAddressStage.sv */
`timescale 1ns/1ps

module binAddressStage import sifhPkg::*; (
    input  logic          clk,
    input  logic          combin_res,
    input  logic          startPulse,
    input  logic          sampleValid,
    input  logic [NP-1:0] sample,
    input  stampArrT      windowLower,
    input  logic          windowLoad,
    output logic          sampleReady,
    output runStateE      runState,
    output binReqT        binReq
);

    logic [SAMPLE_W-1:0] sampleCnt;
    logic [PIX_W-1:0]    pixelCnt;
    logic [ACQ_W-1:0]    acqCnt;
    stampArrT            windowEdge;  // fine window lower edges
    logic                accept;
    logic                take;
    logic                lastSample;
    logic [NP-1:0]       offset;      // sample relative to the pixel's edge
    logic                inWindow;

    assign sampleReady = (runState == RUN_COARSE) || (runState == RUN_FINE);
    assign accept      = sampleValid && sampleReady;
    assign take        = accept && !startPulse;  // a restart drops the sample
    assign lastSample  = (sampleCnt == SAMPLE_W'(DATA_NUM - 1)) &&
                         (pixelCnt == PIX_W'(PIXELS - 1)) &&
                         (acqCnt == ACQ_W'(ACQ_NUM - 1));
    assign offset      = sample - windowEdge[pixelCnt];
    assign inWindow    = (sample >= windowEdge[pixelCnt]) && (offset < NP'(BINS));

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            runState  <= RUN_IDLE;
            sampleCnt <= '0;
            pixelCnt  <= '0;
            acqCnt    <= '0;
        end else if (startPulse) begin
            runState  <= RUN_COARSE;  // restart always from the coarse pass
            sampleCnt <= '0;
            pixelCnt  <= '0;
            acqCnt    <= '0;
        end else if (accept) begin
            sampleCnt <= (sampleCnt == SAMPLE_W'(DATA_NUM - 1)) ? '0 : sampleCnt + 1'b1;
            if (sampleCnt == SAMPLE_W'(DATA_NUM - 1)) begin
                pixelCnt <= (pixelCnt == PIX_W'(PIXELS - 1)) ? '0 : pixelCnt + 1'b1;
                if (pixelCnt == PIX_W'(PIXELS - 1)) begin
                    acqCnt <= (acqCnt == ACQ_W'(ACQ_NUM - 1)) ? '0 : acqCnt + 1'b1;
                end
            end
            if (lastSample) begin
                runState <= (runState == RUN_COARSE) ? RUN_TURN : RUN_IDLE;
            end
        end else if ((runState == RUN_TURN) && windowLoad) begin
            runState <= RUN_FINE;
        end
    end

    always_ff @(posedge clk) begin
        if (windowLoad) begin
            windowEdge <= windowLower;
        end
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            binReq <= '0;
        end else begin
            binReq.valid      <= take && ((runState == RUN_COARSE) || inWindow);
            binReq.lastOfPass <= take && lastSample;
            binReq.pixel      <= pixelCnt;
            binReq.pass       <= (runState == RUN_FINE) ? PASS_FINE : PASS_COARSE;
            binReq.bin        <= (runState == RUN_FINE) ? offset[NB-1:0] : sample[NP-1 -: NB];
        end
    end

    // fine bins must come from samples that really sat inside the window
    fineBinInWindow: assert property (@(posedge clk) disable iff (!combin_res)
        binReq.valid && (binReq.pass == PASS_FINE) |->
            (int'($past(sample)) == int'(windowEdge[binReq.pixel]) + int'(binReq.bin)));

endmodule

/* source/sifhPkg.sv */
package sifhPkg;

    localparam int NP         = 8;                   // timestamp width
    localparam int NB         = 4;                   // bin address width
    localparam int BINS       = 1 << NB;             // bins per pixel histogram
    localparam int PIXELS     = 4;
    localparam int PIX_W      = 2;
    localparam int DATA_NUM   = 8;                   // samples per pixel per acquisition
    localparam int ACQ_NUM    = 2;                   // acquisitions per pass
    localparam int SAMPLE_W   = $clog2(DATA_NUM);
    localparam int ACQ_W      = $clog2(ACQ_NUM);
    localparam int COUNT_W    = 8;
    localparam int MAX_COUNT  = DATA_NUM * ACQ_NUM;  // top count a bin can reach
    localparam int HIST_DEPTH = PIXELS * BINS;
    localparam int COARSE_W   = 1 << (NP - NB);      // one coarse bin in timestamp units
    localparam int SB         = 1 << (NP - NB - 1);  // half a coarse bin
    localparam int WIN_MAX    = (1 << NP) - COARSE_W;
    localparam int AXI_AW     = 5;
    localparam int AXI_DW     = 32;

    typedef enum logic {PASS_COARSE, PASS_FINE} passE;

    typedef enum logic [1:0] {RUN_IDLE, RUN_COARSE, RUN_TURN, RUN_FINE} runStateE;

    // word index of the register map, address bits 4:2
    typedef enum logic [2:0] {
        REG_CTRL, REG_STATUS, REG_RES0, REG_RES1, REG_RES2, REG_RES3
    } regIdxE;

    typedef logic [PIXELS-1:0][NP-1:0] stampArrT;
    typedef logic [PIXELS-1:0][NB-1:0] binArrT;

    typedef struct packed {
        logic [PIX_W-1:0] pixel;
        logic [NB-1:0]    bin;
        passE             pass;
        logic             lastOfPass;  // set even when the sample is dropped
        logic             valid;
    } binReqT;

    typedef struct packed {
        logic [PIX_W-1:0]   pixel;
        logic [NB-1:0]      bin;
        passE               pass;
        logic               lastOfPass;
        logic               valid;
        logic [COUNT_W-1:0] count;     // bin count after this increment
    } binUpdateT;

    typedef struct packed {
        binArrT peakBin;
        passE   pass;
        logic   valid;
    } peakSetT;

    typedef struct packed {
        stampArrT result;
        logic     done;
    } resultSetT;

endpackage
